/* mem_subsys.f */
+incdir+design
design/mem_pkg.sv
design/fetch_port.sv
design/lsu_port.sv
design/axi_arbiter.sv
design/axi_sram.sv
design/mem_subsys.sv
bench/mem_subsys_sva.sv
bench/mem_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the mem_subsys testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f mem_subsys.f \
    --top-module mem_subsys_tb -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/mem_subsys_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* bench/mem_subsys_tb.sv */
`include "mem_config.svh"

module mem_subsys_tb import mem_pkg::*; ();

    localparam int          WAIT_LIMIT = 100;
    localparam logic [31:0] END_ADDR   = `SRAM_BASE + (32'd1 << (`SRAM_DEPTH_LOG2 + 2));

    logic                   clk;
    logic                   rst;
    logic                   fetch_req;
    logic [`MEM_ADDR_W-1:0] fetch_pc;
    logic                   fetch_busy;
    logic [`MEM_DATA_W-1:0] inst;
    logic                   inst_valid;
    logic                   inst_err;
    logic                   lsu_req;
    logic                   lsu_we;
    logic [`MEM_ADDR_W-1:0] lsu_addr;
    lsu_size_e              lsu_size;
    logic                   lsu_unsigned;
    logic [`MEM_DATA_W-1:0] lsu_wdata;
    logic                   lsu_busy;
    logic                   lsu_done;
    logic [`MEM_DATA_W-1:0] lsu_rdata;
    logic                   lsu_err;

    logic [7:0] ref_mem [0:255];    // first 64 words of the sram
    int mismatches   = 0;
    int timeouts     = 0;
    int fetch_issued = 0;
    int lsu_issued   = 0;
    int inst_cnt     = 0;
    int done_cnt     = 0;

    mem_subsys dut0 (.*);

    bind axi_arbiter mem_subsys_sva sva0 (
        .clk(clk), .rst(rst), .gnt_m2(gnt_m2), .m1_state(m1_state), .m2_state(m2_state),
        .m1_rvalid(m1_rvalid), .m1_bvalid(m1_bvalid),
        .m2_rvalid(m2_rvalid), .m2_bvalid(m2_bvalid),
        .s_arvalid(s_arvalid), .s_arready(s_arready), .s_awvalid(s_awvalid),
        .s_awready(s_awready), .s_rvalid(s_rvalid), .s_rready(s_rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (inst_valid)
            inst_cnt++;
        if (lsu_done)
            done_cnt++;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic logic flag(input int which);
        case (which)
            0: return fetch_busy;
            1: return inst_valid;
            2: return lsu_busy;
            default: return lsu_done;
        endcase
    endfunction

    task automatic wait_flag(input int which, input logic level, input string what);
        int n;
        n = 0;
        while (flag(which) !== level && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (flag(which) !== level) begin
            timeouts++;
            $display("Timeout while waiting for %s", what);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [31:0] model_load(input logic [31:0] addr, input lsu_size_e size,
                                               input logic uns);
        logic [7:0] off;
        off = 8'(addr - `SRAM_BASE);
        case (size)
            SIZE_B:  return {{24{ref_mem[off][7] & ~uns}}, ref_mem[off]};
            SIZE_H:  return {{16{ref_mem[off + 8'd1][7] & ~uns}}, ref_mem[off + 8'd1],
                             ref_mem[off]};
            default: return {ref_mem[off + 8'd3], ref_mem[off + 8'd2], ref_mem[off + 8'd1],
                             ref_mem[off]};
        endcase
    endfunction

    function automatic void model_store(input logic [31:0] addr, input lsu_size_e size,
                                        input logic [31:0] data);
        logic [7:0] off;
        off = 8'(addr - `SRAM_BASE);
        ref_mem[off] = data[7:0];
        if (size != SIZE_B)
            ref_mem[off + 8'd1] = data[15:8];
        if (size == SIZE_W) begin
            ref_mem[off + 8'd2] = data[23:16];
            ref_mem[off + 8'd3] = data[31:24];
        end
    endfunction

    task automatic fetch_access(input logic [31:0] addr, output logic [31:0] data,
                                output logic err);
        wait_flag(0, 1'b0, "fetch_busy to fall");
        fetch_req = 1'b1;
        fetch_pc  = addr;
        fetch_issued++;
        tick();
        fetch_req = 1'b0;
        wait_flag(1, 1'b1, "inst_valid");
        data = inst;
        err  = inst_err;
    endtask

    task automatic lsu_access(input logic we, input logic [31:0] addr, input lsu_size_e size,
                              input logic uns, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        wait_flag(2, 1'b0, "lsu_busy to fall");
        lsu_req      = 1'b1;
        lsu_we       = we;
        lsu_addr     = addr;
        lsu_size     = size;
        lsu_unsigned = uns;
        lsu_wdata    = wdata;
        lsu_issued++;
        tick();
        lsu_req = 1'b0;
        wait_flag(3, 1'b1, "lsu_done");
        rdata = lsu_rdata;
        err   = lsu_err;
    endtask

    task automatic store(input string name, input logic [31:0] addr, input lsu_size_e size,
                         input logic [31:0] data);
        logic [31:0] d;
        logic        e;
        lsu_access(1'b1, addr, size, 1'b0, data, d, e);
        model_store(addr, size, data);
        check_value(name, 32'd0, {31'd0, e});
    endtask

    task automatic load_check(input string name, input logic [31:0] addr,
                              input lsu_size_e size, input logic uns);
        logic [31:0] d;
        logic        e;
        lsu_access(1'b0, addr, size, uns, 32'd0, d, e);
        check_value(name, model_load(addr, size, uns), d);
        check_value(name, 32'd0, {31'd0, e});
    endtask

    task automatic fetch_check(input string name, input logic [31:0] addr);
        logic [31:0] d;
        logic        e;
        fetch_access(addr, d, e);
        check_value(name, model_load(addr, SIZE_W, 1'b0), d);
        check_value(name, 32'd0, {31'd0, e});
    endtask

    task automatic fault_check(input string name, input logic is_fetch, input logic we,
                               input logic [31:0] addr);
        logic [31:0] d;
        logic        e;
        if (is_fetch)
            fetch_access(addr, d, e);
        else
            lsu_access(we, addr, SIZE_W, 1'b0, 32'hdead_beef, d, e);
        check_value(name, 32'd1, {31'd0, e});
        if (!we)
            check_value(name, 32'd0, d);    // faulting reads return zero
    endtask

    // random size, aligned offset, load or store
    task automatic random_op(input string name, input int unsigned idx);
        lsu_size_e   size;
        int unsigned off;
        logic [31:0] addr;
        size = lsu_size_e'(2'($urandom % 3));
        off  = $urandom % 4;
        if (size == SIZE_H)
            off = off & 2;
        else if (size == SIZE_W)
            off = 0;
        addr = `SRAM_BASE + 32'(idx * 4 + off);
        if (1'($urandom))
            store(name, addr, size, $urandom);
        else
            load_check(name, addr, size, 1'($urandom));
    endtask

    initial begin
        logic [31:0] a;
        int unsigned w1;
        int unsigned w2;
        int unsigned d1;
        int unsigned d2;
        void'($urandom(21));
        rst          = 1'b1;
        fetch_req    = 1'b0;
        fetch_pc     = '0;
        lsu_req      = 1'b0;
        lsu_we       = 1'b0;
        lsu_addr     = '0;
        lsu_size     = SIZE_W;
        lsu_unsigned = 1'b0;
        lsu_wdata    = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        tick();
        check_value("reset_flags", 32'd0, {28'd0, fetch_busy, lsu_busy, inst_valid, lsu_done});

        for (int i = 0; i < 64; i++) begin
            a = `SRAM_BASE + 32'(i * 4);
            store("init_store", a, SIZE_W, fill_word(a));
        end
        store("word_store", `SRAM_BASE + 32'h10, SIZE_W, 32'h1234_5678);
        fetch_check("fetch_after_store", `SRAM_BASE + 32'h10);

        // partial stores merge into known words
        store("sb_store", `SRAM_BASE + 32'h21, SIZE_B, 32'h0000_00a5);
        store("sh_store", `SRAM_BASE + 32'h22, SIZE_H, 32'h0000_beef);
        load_check("merged_word", `SRAM_BASE + 32'h20, SIZE_W, 1'b0);
        store("sh_store_low", `SRAM_BASE + 32'h24, SIZE_H, 32'hffff_1234);
        store("sb_store_top", `SRAM_BASE + 32'h27, SIZE_B, 32'h0000_0077);
        load_check("merged_word_2", `SRAM_BASE + 32'h24, SIZE_W, 1'b0);

        store("sign_word", `SRAM_BASE + 32'h30, SIZE_W, 32'h80f1_9fe4);   // every lane msb set
        for (int k = 0; k < 4; k++) begin
            load_check("lb_unsigned", `SRAM_BASE + 32'h30 + 32'(k), SIZE_B, 1'b1);
            load_check("lb_signed", `SRAM_BASE + 32'h30 + 32'(k), SIZE_B, 1'b0);
        end
        for (int k = 0; k < 4; k += 2) begin
            load_check("lh_unsigned", `SRAM_BASE + 32'h30 + 32'(k), SIZE_H, 1'b1);
            load_check("lh_signed", `SRAM_BASE + 32'h30 + 32'(k), SIZE_H, 1'b0);
        end

        // fetch in the low half, lsu in the high half
        for (int i = 0; i < 16; i++) begin
            w1 = $urandom % 32;
            w2 = 32 + $urandom % 32;
            d1 = (i == 0) ? 0 : $urandom % 3;
            d2 = (i == 0) ? 0 : $urandom % 3;
            fork
                begin
                    repeat (d1) tick();
                    fetch_check("overlap_fetch", `SRAM_BASE + 32'(w1 * 4));
                end
                begin
                    repeat (d2) tick();
                    random_op("overlap_lsu", w2);
                end
            join
        end

        fault_check("low_load", 1'b0, 1'b0, `SRAM_BASE - 32'd4);
        fault_check("low_fetch", 1'b1, 1'b0, `SRAM_BASE - 32'd4);
        fault_check("low_store", 1'b0, 1'b1, `SRAM_BASE - 32'h1000);   // would alias word 0
        fault_check("end_load", 1'b0, 1'b0, END_ADDR);
        fault_check("end_fetch", 1'b1, 1'b0, END_ADDR);
        fault_check("end_store", 1'b0, 1'b1, END_ADDR);           // would alias word 0
        fault_check("end_store_2", 1'b0, 1'b1, END_ADDR + 32'd4);
        load_check("alias_word_0", `SRAM_BASE, SIZE_W, 1'b0);
        load_check("alias_word_1", `SRAM_BASE + 32'd4, SIZE_W, 1'b0);

        for (int i = 0; i < 200; i++) begin
            w1 = $urandom % 64;
            if ($urandom % 3 == 0)
                fetch_check("random_fetch", `SRAM_BASE + 32'(w1 * 4));
            else
                random_op("random_lsu", w1);
        end

        tick();
        check_value("fetch_count", 32'(fetch_issued), 32'(inst_cnt));
        check_value("lsu_count", 32'(lsu_issued), 32'(done_cnt));
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, dut0.u_arb.sva0.fail_cnt);
        if (mismatches == 0 && timeouts == 0 && dut0.u_arb.sva0.fail_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* bench/mem_subsys_sva.sv */
module mem_subsys_sva (
    input logic       clk,
    input logic       rst,
    input logic       gnt_m2,
    input logic [1:0] m1_state,
    input logic [1:0] m2_state,
    input logic       m1_rvalid,
    input logic       m1_bvalid,
    input logic       m2_rvalid,
    input logic       m2_bvalid,
    input logic       s_arvalid,
    input logic       s_arready,
    input logic       s_awvalid,
    input logic       s_awready,
    input logic       s_rvalid,
    input logic       s_rready
);

    localparam logic [1:0] BUSY = 2'd2;

    int   fail_cnt = 0;             // read by the bench at the end
    logic rd_out;                   // ar accepted, r not yet taken

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_out <= 1'b0;
        else if (s_arvalid && s_arready)
            rd_out <= 1'b1;
        else if (s_rvalid && s_rready)
            rd_out <= 1'b0;
    end

    // only one master sees a response, and only the one holding a transaction
    a_one_resp: assert property (@(posedge clk) disable iff (rst)
        !((m1_rvalid || m1_bvalid) && (m2_rvalid || m2_bvalid))
        && (!(m1_rvalid || m1_bvalid) || m1_state == BUSY)
        && (!(m2_rvalid || m2_bvalid) || m2_state == BUSY))
        else begin
            $error("a response reached a master without a transaction");
            fail_cnt++;
        end

    a_grant_hold: assert property (@(posedge clk) disable iff (rst)
        ((gnt_m2 ? m2_state : m1_state) == BUSY) |=> $stable(gnt_m2))
        else begin
            $error("grant moved while its owner was busy");
            fail_cnt++;
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        s_arvalid && !s_arready |=> s_arvalid)
        else begin
            $error("s_arvalid dropped before it was accepted");
            fail_cnt++;
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        s_awvalid && !s_awready |=> s_awvalid)
        else begin
            $error("s_awvalid dropped before it was accepted");
            fail_cnt++;
        end

    a_r_outstanding: assert property (@(posedge clk) disable iff (rst)
        s_rvalid |-> rd_out)
        else begin
            $error("s_rvalid high with no read outstanding");
            fail_cnt++;
        end

endmodule

/* design/mem_subsys.sv */
`include "mem_config.svh"

module mem_subsys import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   fetch_req,
    input  logic [`MEM_ADDR_W-1:0] fetch_pc,
    output logic                   fetch_busy,
    output logic [`MEM_DATA_W-1:0] inst,
    output logic                   inst_valid,
    output logic                   inst_err,

    input  logic                   lsu_req,
    input  logic                   lsu_we,
    input  logic [`MEM_ADDR_W-1:0] lsu_addr,
    input  lsu_size_e              lsu_size,
    input  logic                   lsu_unsigned,
    input  logic [`MEM_DATA_W-1:0] lsu_wdata,
    output logic                   lsu_busy,
    output logic                   lsu_done,
    output logic [`MEM_DATA_W-1:0] lsu_rdata,
    output logic                   lsu_err
);

    // fetch master, read side only
    logic [`MEM_ADDR_W-1:0]   m1_araddr;
    logic                     m1_arvalid, m1_arready, m1_rvalid, m1_rready;
    logic [`MEM_DATA_W-1:0]   m1_rdata;
    axi_resp_e                m1_rresp;

    logic [`MEM_ADDR_W-1:0]   m2_araddr, m2_awaddr;
    logic                     m2_arvalid, m2_arready, m2_rvalid, m2_rready;
    logic                     m2_awvalid, m2_awready, m2_wvalid, m2_wready;
    logic                     m2_bvalid, m2_bready;
    logic [`MEM_DATA_W-1:0]   m2_rdata, m2_wdata;
    logic [`MEM_DATA_W/8-1:0] m2_wstrb;
    axi_resp_e                m2_rresp, m2_bresp;

    logic [`MEM_ADDR_W-1:0]   s_araddr, s_awaddr;
    logic                     s_arvalid, s_arready, s_rvalid, s_rready;
    logic                     s_awvalid, s_awready, s_wvalid, s_wready;
    logic                     s_bvalid, s_bready;
    logic [`MEM_DATA_W-1:0]   s_rdata, s_wdata;
    logic [`MEM_DATA_W/8-1:0] s_wstrb;
    axi_resp_e                s_rresp, s_bresp;

    fetch_port u_fetch (
        .*,
        .m_araddr(m1_araddr), .m_arvalid(m1_arvalid), .m_arready(m1_arready),
        .m_rdata(m1_rdata), .m_rresp(m1_rresp), .m_rvalid(m1_rvalid), .m_rready(m1_rready)
    );

    lsu_port u_lsu (
        .*,
        .m_araddr(m2_araddr), .m_arvalid(m2_arvalid), .m_arready(m2_arready),
        .m_rdata(m2_rdata), .m_rresp(m2_rresp), .m_rvalid(m2_rvalid), .m_rready(m2_rready),
        .m_awaddr(m2_awaddr), .m_awvalid(m2_awvalid), .m_awready(m2_awready),
        .m_wdata(m2_wdata), .m_wstrb(m2_wstrb), .m_wvalid(m2_wvalid), .m_wready(m2_wready),
        .m_bresp(m2_bresp), .m_bvalid(m2_bvalid), .m_bready(m2_bready)
    );

    axi_arbiter u_arb (
        .*,
        .m1_awaddr('0), .m1_awvalid(1'b0), .m1_awready(),   // fetch never writes
        .m1_wdata('0), .m1_wstrb('0), .m1_wvalid(1'b0), .m1_wready(),
        .m1_bresp(), .m1_bvalid(), .m1_bready(1'b0)
    );

    axi_sram u_sram (.*);

endmodule

/* design/axi_sram.sv */
`include "mem_config.svh"

module axi_sram import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [`MEM_ADDR_W-1:0]   s_araddr,
    input  logic                     s_arvalid,
    output logic                     s_arready,
    output logic [`MEM_DATA_W-1:0]   s_rdata,
    output axi_resp_e                s_rresp,
    output logic                     s_rvalid,
    input  logic                     s_rready,
    input  logic [`MEM_ADDR_W-1:0]   s_awaddr,
    input  logic                     s_awvalid,
    output logic                     s_awready,
    input  logic [`MEM_DATA_W-1:0]   s_wdata,
    input  logic [`MEM_DATA_W/8-1:0] s_wstrb,
    input  logic                     s_wvalid,
    output logic                     s_wready,
    output axi_resp_e                s_bresp,
    output logic                     s_bvalid,
    input  logic                     s_bready
);

    localparam int CNT_W = $clog2(`SRAM_LATENCY + 1);

    logic [`MEM_DATA_W-1:0]        mem [0:(1 << `SRAM_DEPTH_LOG2)-1];
    logic                          pend;            // one transaction in flight
    logic                          is_wr;
    logic [CNT_W-1:0]              cnt;
    axi_resp_e                     resp_q;
    logic                          rd_go;
    logic                          wr_go;
    logic                          rd_ok;
    logic                          wr_ok;
    mem_word_u                     wr_in;
    mem_word_u                     merged;

    function automatic logic in_range(input logic [`MEM_ADDR_W-1:0] a);
        logic [`MEM_ADDR_W-1:0] off;
        off = a - `SRAM_BASE;                       // wraps below base
        return off[`MEM_ADDR_W-1:`SRAM_DEPTH_LOG2+2] == '0;
    endfunction

    assign s_arready = !pend;
    assign s_awready = !pend && !s_arvalid;         // reads first
    assign s_wready  = s_awready;
    assign rd_go     = s_arvalid && s_arready;
    assign wr_go     = s_awvalid && s_awready && s_wvalid && s_wready;
    assign rd_ok     = in_range(s_araddr);
    assign wr_ok     = in_range(s_awaddr);
    assign s_rresp   = resp_q;
    assign s_bresp   = resp_q;

    // strobed lanes replace the stored ones
    always_comb begin
        wr_in.word  = s_wdata;
        merged.word = mem[s_awaddr[`SRAM_DEPTH_LOG2+1:2]];
        for (int i = 0; i < `MEM_DATA_W/8; i++)
            if (s_wstrb[i])
                merged.lane[i] = wr_in.lane[i];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend     <= 1'b0;
            is_wr    <= 1'b0;
            cnt      <= '0;
            s_rvalid <= 1'b0;
            s_bvalid <= 1'b0;
        end else if (!pend) begin
            if (rd_go || wr_go) begin
                pend  <= 1'b1;
                is_wr <= wr_go;
                cnt   <= CNT_W'(`SRAM_LATENCY - 1);
            end
        end else if (!s_rvalid && !s_bvalid) begin
            if (cnt == '0) begin
                s_rvalid <= !is_wr;
                s_bvalid <= is_wr;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end else if (s_rvalid && s_rready || s_bvalid && s_bready) begin
            pend     <= 1'b0;
            s_rvalid <= 1'b0;
            s_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            s_rdata <= rd_ok ? mem[s_araddr[`SRAM_DEPTH_LOG2+1:2]] : '0;
            resp_q  <= rd_ok ? OKAY : SLVERR;
        end
        if (wr_go) begin
            if (wr_ok)
                mem[s_awaddr[`SRAM_DEPTH_LOG2+1:2]] <= merged.word;
            resp_q <= wr_ok ? OKAY : SLVERR;
        end
    end

endmodule

/* design/axi_arbiter.sv */
`include "mem_config.svh"

module axi_arbiter import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    input  logic [`MEM_ADDR_W-1:0]   m1_araddr,
    input  logic                     m1_arvalid,
    output logic                     m1_arready,
    output logic [`MEM_DATA_W-1:0]   m1_rdata,
    output axi_resp_e                m1_rresp,
    output logic                     m1_rvalid,
    input  logic                     m1_rready,
    input  logic [`MEM_ADDR_W-1:0]   m1_awaddr,
    input  logic                     m1_awvalid,
    output logic                     m1_awready,
    input  logic [`MEM_DATA_W-1:0]   m1_wdata,
    input  logic [`MEM_DATA_W/8-1:0] m1_wstrb,
    input  logic                     m1_wvalid,
    output logic                     m1_wready,
    output axi_resp_e                m1_bresp,
    output logic                     m1_bvalid,
    input  logic                     m1_bready,

    input  logic [`MEM_ADDR_W-1:0]   m2_araddr,
    input  logic                     m2_arvalid,
    output logic                     m2_arready,
    output logic [`MEM_DATA_W-1:0]   m2_rdata,
    output axi_resp_e                m2_rresp,
    output logic                     m2_rvalid,
    input  logic                     m2_rready,
    input  logic [`MEM_ADDR_W-1:0]   m2_awaddr,
    input  logic                     m2_awvalid,
    output logic                     m2_awready,
    input  logic [`MEM_DATA_W-1:0]   m2_wdata,
    input  logic [`MEM_DATA_W/8-1:0] m2_wstrb,
    input  logic                     m2_wvalid,
    output logic                     m2_wready,
    output axi_resp_e                m2_bresp,
    output logic                     m2_bvalid,
    input  logic                     m2_bready,

    output logic [`MEM_ADDR_W-1:0]   s_araddr,
    output logic                     s_arvalid,
    input  logic                     s_arready,
    input  logic [`MEM_DATA_W-1:0]   s_rdata,
    input  axi_resp_e                s_rresp,
    input  logic                     s_rvalid,
    output logic                     s_rready,
    output logic [`MEM_ADDR_W-1:0]   s_awaddr,
    output logic                     s_awvalid,
    input  logic                     s_awready,
    output logic [`MEM_DATA_W-1:0]   s_wdata,
    output logic [`MEM_DATA_W/8-1:0] s_wstrb,
    output logic                     s_wvalid,
    input  logic                     s_wready,
    input  axi_resp_e                s_bresp,
    input  logic                     s_bvalid,
    output logic                     s_bready
);

    typedef enum logic [1:0] {FREE, WAIT, BUSY} port_state_e;

    port_state_e m1_state;
    port_state_e m2_state;
    logic        gnt_m2;        // 0 = fetch side, 1 = lsu side
    logic        own_lock;

    function automatic port_state_e step(port_state_e cur, logic req_hs, logic req_v,
                                         logic rsp_hs);
        if (req_hs)
            return BUSY;
        if (req_v)
            return WAIT;
        if (rsp_hs)
            return FREE;
        return cur;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m1_state <= FREE;
            m2_state <= FREE;
        end else begin
            m1_state <= step(m1_state,
                m1_arvalid && m1_arready || m1_awvalid && m1_awready && m1_wvalid && m1_wready,
                m1_arvalid || m1_awvalid && m1_wvalid,
                m1_rvalid && m1_rready || m1_bvalid && m1_bready);
            m2_state <= step(m2_state,
                m2_arvalid && m2_arready || m2_awvalid && m2_awready && m2_wvalid && m2_wready,
                m2_arvalid || m2_awvalid && m2_wvalid,
                m2_rvalid && m2_rready || m2_bvalid && m2_bready);
        end
    end

    // owner keeps the bus from its request handshake until its response
    assign own_lock = (gnt_m2 ? m2_state : m1_state) == BUSY
                   || s_arvalid && s_arready
                   || s_awvalid && s_awready && s_wvalid && s_wready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            gnt_m2 <= 1'b0;
        else if (!own_lock)
            gnt_m2 <= !(m1_state == WAIT || m2_state == FREE);  // m1 wins ties
    end

    // requests from the granted master
    assign s_araddr  = gnt_m2 ? m2_araddr  : m1_araddr;
    assign s_arvalid = gnt_m2 ? m2_arvalid : m1_arvalid;
    assign s_rready  = gnt_m2 ? m2_rready  : m1_rready;
    assign s_awaddr  = gnt_m2 ? m2_awaddr  : m1_awaddr;
    assign s_awvalid = gnt_m2 ? m2_awvalid : m1_awvalid;
    assign s_wdata   = gnt_m2 ? m2_wdata   : m1_wdata;
    assign s_wstrb   = gnt_m2 ? m2_wstrb   : m1_wstrb;
    assign s_wvalid  = gnt_m2 ? m2_wvalid  : m1_wvalid;
    assign s_bready  = gnt_m2 ? m2_bready  : m1_bready;

    // responses back to the owner only, zero elsewhere
    assign m1_arready = s_arready && !gnt_m2;
    assign m1_rdata   = gnt_m2 ? '0 : s_rdata;
    assign m1_rresp   = gnt_m2 ? OKAY : s_rresp;
    assign m1_rvalid  = s_rvalid && !gnt_m2;
    assign m1_awready = s_awready && !gnt_m2;
    assign m1_wready  = s_wready && !gnt_m2;
    assign m1_bresp   = gnt_m2 ? OKAY : s_bresp;
    assign m1_bvalid  = s_bvalid && !gnt_m2;

    assign m2_arready = s_arready && gnt_m2;
    assign m2_rdata   = gnt_m2 ? s_rdata : '0;
    assign m2_rresp   = gnt_m2 ? s_rresp : OKAY;
    assign m2_rvalid  = s_rvalid && gnt_m2;
    assign m2_awready = s_awready && gnt_m2;
    assign m2_wready  = s_wready && gnt_m2;
    assign m2_bresp   = gnt_m2 ? s_bresp : OKAY;
    assign m2_bvalid  = s_bvalid && gnt_m2;

endmodule

/* design/lsu_port.sv */
`include "mem_config.svh"

module lsu_port import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     lsu_req,
    input  logic                     lsu_we,
    input  logic [`MEM_ADDR_W-1:0]   lsu_addr,
    input  lsu_size_e                lsu_size,
    input  logic                     lsu_unsigned,
    input  logic [`MEM_DATA_W-1:0]   lsu_wdata,
    output logic                     lsu_busy,
    output logic                     lsu_done,
    output logic [`MEM_DATA_W-1:0]   lsu_rdata,
    output logic                     lsu_err,

    output logic [`MEM_ADDR_W-1:0]   m_araddr,
    output logic                     m_arvalid,
    input  logic                     m_arready,
    input  logic [`MEM_DATA_W-1:0]   m_rdata,
    input  axi_resp_e                m_rresp,
    input  logic                     m_rvalid,
    output logic                     m_rready,
    output logic [`MEM_ADDR_W-1:0]   m_awaddr,
    output logic                     m_awvalid,
    input  logic                     m_awready,
    output logic [`MEM_DATA_W-1:0]   m_wdata,
    output logic [`MEM_DATA_W/8-1:0] m_wstrb,
    output logic                     m_wvalid,
    input  logic                     m_wready,
    input  axi_resp_e                m_bresp,
    input  logic                     m_bvalid,
    output logic                     m_bready
);

    typedef enum logic [1:0] {IDLE, ISSUE, RESP} lsu_state_e;

    lsu_state_e               state;
    logic                     we_q;
    logic                     uns_q;
    lsu_size_e                size_q;
    logic [`MEM_ADDR_W-1:0]   addr_q;
    mem_word_u                st_word;
    logic [`MEM_DATA_W/8-1:0] st_strb;
    mem_word_u                ld_word;
    logic [7:0]               ld_byte;
    logic [15:0]              ld_half;
    logic [`MEM_DATA_W-1:0]   ld_ext;
    logic                     start;
    logic                     req_hs;
    logic                     r_hs;
    logic                     b_hs;

    assign start     = lsu_req && state == IDLE;
    assign req_hs    = m_arvalid && m_arready || m_awvalid && m_awready && m_wvalid && m_wready;
    assign r_hs      = m_rvalid && m_rready;
    assign b_hs      = m_bvalid && m_bready;
    assign lsu_busy  = state != IDLE;
    assign m_araddr  = addr_q;
    assign m_awaddr  = addr_q;
    assign m_arvalid = state == ISSUE && !we_q;
    assign m_awvalid = state == ISSUE && we_q;
    assign m_wvalid  = state == ISSUE && we_q;  // aw and w go together
    assign m_rready  = state == RESP;
    assign m_bready  = state == RESP;

    // store data moved into its lane(s)
    always_comb begin
        st_word = '0;
        st_strb = '0;
        case (lsu_size)
            SIZE_B: begin
                st_word.lane[lsu_addr[1:0]] = lsu_wdata[7:0];
                st_strb[lsu_addr[1:0]]      = 1'b1;
            end
            SIZE_H: begin
                st_word.lane[{lsu_addr[1], 1'b0}] = lsu_wdata[7:0];
                st_word.lane[{lsu_addr[1], 1'b1}] = lsu_wdata[15:8];
                st_strb = lsu_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_word.word = lsu_wdata;
                st_strb      = '1;
            end
        endcase
    end

    // load lane pick and extension
    always_comb begin
        ld_word.word = m_rdata;
        ld_byte      = ld_word.lane[addr_q[1:0]];
        ld_half      = {ld_word.lane[{addr_q[1], 1'b1}], ld_word.lane[{addr_q[1], 1'b0}]};
        case (size_q)
            SIZE_B:  ld_ext = {{(`MEM_DATA_W-8){ld_byte[7] & ~uns_q}}, ld_byte};
            SIZE_H:  ld_ext = {{(`MEM_DATA_W-16){ld_half[15] & ~uns_q}}, ld_half};
            default: ld_ext = ld_word.word;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            case (state)
                IDLE:  if (lsu_req) state <= ISSUE;
                ISSUE: if (req_hs) state <= RESP;
                RESP: begin
                    if (r_hs || b_hs) begin
                        state    <= IDLE;
                        lsu_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q    <= lsu_we;
            uns_q   <= lsu_unsigned;
            size_q  <= lsu_size;
            addr_q  <= lsu_addr;
            m_wdata <= st_word.word;
            m_wstrb <= st_strb;
        end
        if (r_hs) begin
            lsu_rdata <= ld_ext;
            lsu_err   <= (m_rresp != OKAY);
        end
        if (b_hs) begin
            lsu_rdata <= '0;
            lsu_err   <= (m_bresp != OKAY);
        end
    end

endmodule

/* design/fetch_port.sv */
`include "mem_config.svh"

module fetch_port import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   fetch_req,
    input  logic [`MEM_ADDR_W-1:0] fetch_pc,
    output logic                   fetch_busy,
    output logic [`MEM_DATA_W-1:0] inst,
    output logic                   inst_valid,
    output logic                   inst_err,

    output logic [`MEM_ADDR_W-1:0] m_araddr,
    output logic                   m_arvalid,
    input  logic                   m_arready,
    input  logic [`MEM_DATA_W-1:0] m_rdata,
    input  axi_resp_e              m_rresp,
    input  logic                   m_rvalid,
    output logic                   m_rready
);

    logic start;
    logic r_done;

    assign start    = fetch_req && !fetch_busy;
    assign r_done   = m_rvalid && m_rready;
    assign m_rready = fetch_busy;               // always sink the response

    // busy is the whole state: idle or waiting on the bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_busy <= 1'b0;
            m_arvalid  <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            if (start) begin
                fetch_busy <= 1'b1;
                m_arvalid  <= 1'b1;
            end else begin
                if (m_arvalid && m_arready)
                    m_arvalid <= 1'b0;          // address taken
                if (r_done) begin
                    fetch_busy <= 1'b0;
                    inst_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            m_araddr <= fetch_pc;
        if (r_done) begin
            inst     <= m_rdata;
            inst_err <= (m_rresp != OKAY);
        end
    end

endmodule

/* design/mem_pkg.sv */
`include "mem_config.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axi_resp_e;

    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } lsu_size_e;

    // lane 0 is bits 7:0
    typedef union packed {
        logic [`MEM_DATA_W-1:0]           word;
        logic [`MEM_DATA_W/8-1:0][7:0]    lane;
    } mem_word_u;

endpackage

/* design/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// sram geometry, depth in words
`define SRAM_DEPTH_LOG2 10
`define SRAM_BASE 32'h8000_0000

// cycles from accepted request to response valid, at least 1
`define SRAM_LATENCY 2

`endif
